// ==== logic/rename_defs.svh ====
// Register counts and field widths for the rename stage
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Logical register file with r0 hard-wired to zero
`define RN_LREGS    32

// Physical register count and free list depth
`define RN_PREGS    64

// Index widths
`define RN_LRF_AW   5
`define RN_PRF_AW   6

// Program counter width
`define RN_PC_W     32

`endif

// ==== logic/rename_pkg.sv ====
// Opcode enum and packed structs for decode, rename, commit and writeback
`include "rename_defs.svh"

package rename_pkg;

   // Major opcode from instruction bits 31..26
   typedef enum logic [5:0] {
      OP_NOP    = 6'h00,
      OP_ALU_RR = 6'h01,
      OP_ALU_RI = 6'h02,
      OP_LOAD   = 6'h03,
      OP_STORE  = 6'h04,
      OP_BRANCH = 6'h05,
      OP_JAL    = 6'h06
   } op_e;

   typedef logic [`RN_LRF_AW-1:0] lreg_t;
   typedef logic [`RN_PRF_AW-1:0] preg_t;

   typedef struct packed {
      op_e                  op;
      logic [`RN_PC_W-1:0]  pc;
      logic [15:0]          imm;
      lreg_t                lrs1;
      logic                 lrs1_re;
      lreg_t                lrs2;
      logic                 lrs2_re;
      lreg_t                lrd;
      logic                 lrd_we;
   } dec_uop_t;

   typedef struct packed {
      op_e                  op;
      logic [`RN_PC_W-1:0]  pc;
      logic [15:0]          imm;
      preg_t                prs1;
      logic                 prs1_re;
      preg_t                prs2;
      logic                 prs2_re;
      lreg_t                lrd;
      preg_t                prd;
      logic                 prd_we;
      preg_t                pfree;   // Old mapping of lrd that commit frees
   } ren_uop_t;

   typedef struct packed {
      logic                 fire;
      lreg_t                lrd;
      preg_t                prd;
      logic                 prd_we;
      preg_t                pfree;
   } cmt_t;

   typedef struct packed {
      logic                 valid;
      preg_t                preg;
   } wb_t;

endpackage

// ==== logic/rn_decode.sv ====
// Instruction decoder producing a micro-op with logical registers and enables
`timescale 1ns/1ps
`include "rename_defs.svh"

module rn_decode
   import rename_pkg::*;
(
   input  logic [31:0]          instr,
   input  logic [`RN_PC_W-1:0]  pc,
   output dec_uop_t             uop
);

   op_e   op;
   lreg_t rd;

   assign rd = instr[25:21];

   // Unknown major opcodes fall back to NOP
   always_comb begin
      case (instr[31:26])
         OP_ALU_RR: op = OP_ALU_RR;
         OP_ALU_RI: op = OP_ALU_RI;
         OP_LOAD:   op = OP_LOAD;
         OP_STORE:  op = OP_STORE;
         OP_BRANCH: op = OP_BRANCH;
         OP_JAL:    op = OP_JAL;
         default:   op = OP_NOP;
      endcase
   end

   always_comb begin
      uop.op      = op;
      uop.pc      = pc;
      uop.imm     = instr[15:0];
      uop.lrs1    = instr[20:16];
      uop.lrs2    = instr[15:11];
      uop.lrd     = rd;
      uop.lrs1_re = 1'b0;
      uop.lrs2_re = 1'b0;
      uop.lrd_we  = 1'b0;
      case (op)
         OP_ALU_RR: begin
            uop.lrs1_re = 1'b1;
            uop.lrs2_re = 1'b1;
            uop.lrd_we  = 1'b1;
         end
         OP_STORE, OP_BRANCH: begin  // Two sources and no destination
            uop.lrs1_re = 1'b1;
            uop.lrs2_re = 1'b1;
         end
         OP_ALU_RI, OP_LOAD: begin
            uop.lrs1_re = 1'b1;
            uop.lrd_we  = 1'b1;
         end
         OP_JAL:  uop.lrd_we = 1'b1; // Link register only
         default: ;
      endcase
      // r0 is never renamed
      if (rd == '0) begin
         uop.lrd_we = 1'b0;
      end
   end

endmodule

// ==== logic/rn_free_list.sv ====
// Free physical register queue with speculative and committed heads
`timescale 1ns/1ps
`include "rename_defs.svh"

module rn_free_list
   import rename_pkg::*;
(
   input  logic   clk,
   input  logic   arst_n,
   input  logic   pop,
   input  logic   flush,
   input  cmt_t   cmt,
   output preg_t  fl_prd,
   output logic   fl_empty
);

   // Extra MSB tells full from empty
   typedef logic [`RN_PRF_AW:0] ptr_t;

   preg_t fifo_q [`RN_PREGS];
   ptr_t  tail_q;
   ptr_t  spec_head_q;     // Next register handed out at rename
   ptr_t  cmt_head_q;      // Oldest register not yet retired by commit
   ptr_t  cmt_head_nxt;
   logic  push;
   logic  full;

   // A committed writer returns the old mapping of its destination
   assign push = cmt.fire & cmt.prd_we;

   assign cmt_head_nxt = push ? cmt_head_q + 1'b1 : cmt_head_q;

   assign fl_empty = (spec_head_q == tail_q);

   // All free registers are queued once commit has caught up with rename
   assign full = (spec_head_q == cmt_head_q);

   assign fl_prd = fifo_q[spec_head_q[`RN_PRF_AW-1:0]];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // Registers above the logical range start out free, in order
         for (int i = 0; i < `RN_PREGS; i++) begin
            fifo_q[i] <= preg_t'(i + `RN_LREGS);
         end
         tail_q      <= ptr_t'(`RN_PREGS - `RN_LREGS);
         spec_head_q <= '0;
         cmt_head_q  <= '0;
      end else begin
         if (push) begin
            fifo_q[tail_q[`RN_PRF_AW-1:0]] <= cmt.pfree;
            tail_q                        <= tail_q + 1'b1;
         end
         cmt_head_q <= cmt_head_nxt;
         if (flush) begin
            // Give back everything popped after the last commit
            spec_head_q <= cmt_head_nxt;
         end else if (pop) begin
            spec_head_q <= spec_head_q + 1'b1;
         end
      end
   end

   // Rename must stall on an empty list
   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (!arst_n)
      pop |-> !fl_empty
   );

   // Commit can only return what rename took
   a_no_push_full: assert property (
      @(posedge clk) disable iff (!arst_n)
      push |-> !full
   );

endmodule

// ==== logic/rn_rat.sv ====
// Speculative and architectural register alias tables with flush rollback
`timescale 1ns/1ps
`include "rename_defs.svh"

module rn_rat
   import rename_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      fire,
   input  logic      flush,
   input  dec_uop_t  uop,
   input  preg_t     fl_prd,
   input  cmt_t      cmt,
   output preg_t     prs1,
   output preg_t     prs2,
   output preg_t     pfree
);

   preg_t spec_q [`RN_LREGS];   // Read at rename
   preg_t arch_q [`RN_LREGS];   // Updated at commit
   preg_t arch_nxt [`RN_LREGS];
   logic  spec_we;
   logic  arch_we;

   assign spec_we = fire & uop.lrd_we;
   assign arch_we = cmt.fire & cmt.prd_we;

   // Lookups see the table as of this cycle
   assign prs1  = spec_q[uop.lrs1];
   assign prs2  = spec_q[uop.lrs2];
   assign pfree = spec_q[uop.lrd];

   // Architectural table with this cycle's commit folded in
   always_comb begin
      for (int i = 0; i < `RN_LREGS; i++) begin
         arch_nxt[i] = arch_q[i];
      end
      if (arch_we) begin
         arch_nxt[cmt.lrd] = cmt.prd;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // Identity map out of reset
         for (int i = 0; i < `RN_LREGS; i++) begin
            arch_q[i] <= preg_t'(i);
         end
      end else begin
         for (int i = 0; i < `RN_LREGS; i++) begin
            arch_q[i] <= arch_nxt[i];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `RN_LREGS; i++) begin
            spec_q[i] <= preg_t'(i);
         end
      end else if (flush) begin
         // Roll back to committed state
         for (int i = 0; i < `RN_LREGS; i++) begin
            spec_q[i] <= arch_nxt[i];
         end
      end else if (spec_we) begin
         spec_q[uop.lrd] <= fl_prd;
      end
   end

   // r0 stays hard-wired in both tables
   a_no_r0_write: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(spec_we && uop.lrd == '0) && !(arch_we && cmt.lrd == '0)
   );

endmodule

// ==== logic/rn_busytable.sv ====
// Busy table with one bit per physical register, set at allocation and cleared at writeback
`timescale 1ns/1ps
`include "rename_defs.svh"

module rn_busytable
   import rename_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 set_valid,
   input  preg_t                set_preg,
   input  wb_t                  wb,
   input  logic                 flush,
   output logic [`RN_PREGS-1:0] busy
);

   logic [`RN_PREGS-1:0] busy_nxt;

   always_comb begin
      busy_nxt = busy;
      if (wb.valid) begin
         busy_nxt[wb.preg] = 1'b0;
      end
      if (set_valid) begin
         busy_nxt[set_preg] = 1'b1;   // New producer pending
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= '0;
      end else if (flush) begin
         busy <= '0;   // Surviving producers have all written back
      end else begin
         busy <= busy_nxt;
      end
   end

   // Writeback only for registers handed out by rename
   a_wb_busy: assert property (
      @(posedge clk) disable iff (!arst_n || flush)
      wb.valid |-> busy[wb.preg]
   );

endmodule

// ==== logic/rename_unit.sv ====
// Rename stage top with stall logic, stage register and submodule instances
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_unit
   import rename_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 in_valid,
   input  logic [31:0]          instr,
   input  logic [`RN_PC_W-1:0]  pc,
   output logic                 in_ready,
   input  cmt_t                 cmt,
   input  wb_t                  wb,
   input  logic                 flush,
   input  logic                 issue_ready,
   output logic                 out_valid,
   output ren_uop_t             out_uop,
   output logic [`RN_PREGS-1:0] busy
);

   dec_uop_t dec_uop;
   ren_uop_t ren_uop;
   preg_t    fl_prd;
   logic     fl_empty;
   preg_t    prs1;
   preg_t    prs2;
   preg_t    pfree;
   logic     stage_ce;
   logic     rename_fire;
   logic     fl_pop;

   rn_decode u_decode (.instr(instr), .pc(pc), .uop(dec_uop));

   // Stage register empty or draining this cycle
   assign stage_ce    = ~out_valid | issue_ready;
   assign in_ready    = ~fl_empty & ~flush & stage_ce;
   assign rename_fire = in_valid & in_ready;
   assign fl_pop      = rename_fire & dec_uop.lrd_we;

   rn_free_list u_free_list (
      .clk      (clk),
      .arst_n   (arst_n),
      .pop      (fl_pop),
      .flush    (flush),
      .cmt      (cmt),
      .fl_prd   (fl_prd),
      .fl_empty (fl_empty)
   );

   rn_rat u_rat (
      .clk    (clk),
      .arst_n (arst_n),
      .fire   (rename_fire),
      .flush  (flush),
      .uop    (dec_uop),
      .fl_prd (fl_prd),
      .cmt    (cmt),
      .prs1   (prs1),
      .prs2   (prs2),
      .pfree  (pfree)
   );

   rn_busytable u_busytable (
      .clk       (clk),
      .arst_n    (arst_n),
      .set_valid (fl_pop),
      .set_preg  (fl_prd),
      .wb        (wb),
      .flush     (flush),
      .busy      (busy)
   );

   always_comb begin
      ren_uop.op      = dec_uop.op;
      ren_uop.pc      = dec_uop.pc;
      ren_uop.imm     = dec_uop.imm;
      ren_uop.prs1    = prs1;
      ren_uop.prs1_re = dec_uop.lrs1_re;
      ren_uop.prs2    = prs2;
      ren_uop.prs2_re = dec_uop.lrs2_re;
      ren_uop.lrd     = dec_uop.lrd;
      ren_uop.prd     = fl_prd;   // Head entry is only consumed when lrd_we
      ren_uop.prd_we  = dec_uop.lrd_we;
      ren_uop.pfree   = pfree;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (flush) begin
         out_valid <= 1'b0;
      end else if (stage_ce) begin
         out_valid <= rename_fire;
      end
   end

   always_ff @(posedge clk) begin
      if (stage_ce) begin
         out_uop <= ren_uop;
      end
   end

   // Held uop must not change under back-pressure
   a_hold_uop: assert property (
      @(posedge clk) disable iff (!arst_n)
      (out_valid && !issue_ready) |=> $stable(out_uop)
   );

endmodule

// ==== bench/rename_unit_tb.sv ====
// Testbench for the rename stage with golden records, back-pressure and output checks
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_unit_tb
   import rename_pkg::*;
();

   localparam int WAIT_LIMIT = 200;   // Cycles per wait

   // Expected fields of one renamed uop
   typedef struct packed {
      logic [31:0]           pc;
      logic [5:0]            op;
      logic [15:0]           imm;
      logic [`RN_LRF_AW-1:0] lrd;
      logic [1:0]            reads;   // Read enables of rs1 and rs2
      logic [31:0]           prs1;
      logic [31:0]           prs2;
      logic [31:0]           prd;
      logic [31:0]           pfree;
      logic [31:0]           prd_we;
   } exp_uop_t;

   logic                 clk;
   logic                 arst_n;
   logic                 in_valid;
   logic [31:0]          instr;
   logic [`RN_PC_W-1:0]  pc;
   logic                 in_ready;
   cmt_t                 cmt;
   wb_t                  wb;
   logic                 flush;
   logic                 issue_ready;
   logic                 out_valid;
   ren_uop_t             out_uop;
   logic [`RN_PREGS-1:0] busy;

   exp_uop_t    exp_q[$];     // Accepted, not yet taken by issue
   logic [15:0] lfsr;
   int          checks;
   int          errors;
   int          timeouts;

   rename_unit DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   // Major opcode as decoded, with unknown codes seen as NOP
   function automatic logic [5:0] decoded_op(input logic [5:0] code);
      logic [5:0] op;
      op = OP_NOP;
      if (code inside {OP_ALU_RR, OP_ALU_RI, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL}) begin
         op = code;
      end
      return op;
   endfunction

   // Source read enables {rs1, rs2} per opcode
   function automatic logic [1:0] source_reads(input logic [5:0] op);
      case (op)
         OP_ALU_RR, OP_STORE, OP_BRANCH: return 2'b11;
         OP_ALU_RI, OP_LOAD:             return 2'b10;
         default:                        return 2'b00;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // Holds the instruction from a falling edge until in_ready takes it
   task automatic send_instr(input logic [31:0] word, input exp_uop_t e);
      int waited;
      waited   = 0;
      in_valid = 1'b1;
      instr    = word;
      pc       = e.pc;
      #1;
      while (!in_ready && waited < WAIT_LIMIT) begin
         @(negedge clk);
         #1;
         waited++;
      end
      if (in_ready) begin
         exp_q.push_back(e);   // Taken at the coming rising edge
      end else begin
         timeouts++;
         $display("Timeout at %0t ns, in_ready never rose for pc %h", $time, e.pc);
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic drain_outputs();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         timeouts++;
         $display("Timeout at %0t ns, %0d uops never left the stage", $time, exp_q.size());
      end
      @(negedge clk);   // Stage register now empty
   endtask

   task automatic expect_stall(input int cycles);
      drain_outputs();
      repeat (cycles) begin
         #1;
         check_val("in_ready", 64'(in_ready), 64'd0);
         @(negedge clk);
      end
   endtask

   task automatic apply_commit(input logic [63:0] lrd, prd, we, pfree);
      cmt.fire   = 1'b1;
      cmt.lrd    = lreg_t'(lrd);
      cmt.prd    = preg_t'(prd);
      cmt.prd_we = we[0];
      cmt.pfree  = preg_t'(pfree);
      @(negedge clk);
      cmt = '0;
   endtask

   task automatic pulse_writeback(input logic [63:0] preg);
      wb.valid = 1'b1;
      wb.preg  = preg_t'(preg);
      @(negedge clk);
      wb = '0;
   endtask

   task automatic flush_pipeline();
      drain_outputs();   // Nothing in flight gets dropped
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
   endtask

   // Issue side with random issue_ready and in-order uop checks
   initial begin : issue_side
      ren_uop_t held;
      logic     holding;
      exp_uop_t e;
      holding = 1'b0;
      forever begin
         @(negedge clk);
         issue_ready = lfsr[0];
         lfsr        = lfsr_next(lfsr);
         #1;
         if (holding) begin
            checks++;
            assert (out_uop === held) else begin
               errors++;
               $display("[ERROR] %0t ns out_uop got %h expected %h", $time, out_uop, held);
            end
         end
         if (out_valid && issue_ready) begin
            checks++;
            assert (exp_q.size() > 0) else begin
               errors++;
               $display("Unexpected uop at %0t ns with pc %h", $time, out_uop.pc);
            end
            if (exp_q.size() > 0) begin
               e = exp_q.pop_front();
               check_val("out_uop.pc", 64'(out_uop.pc), 64'(e.pc));
               check_val("out_uop.op", 64'(out_uop.op), 64'(e.op));
               check_val("out_uop.imm", 64'(out_uop.imm), 64'(e.imm));
               check_val("out_uop.lrd", 64'(out_uop.lrd), 64'(e.lrd));
               check_val("out_uop.prs1_re", 64'(out_uop.prs1_re), 64'(e.reads[1]));
               check_val("out_uop.prs2_re", 64'(out_uop.prs2_re), 64'(e.reads[0]));
               check_val("out_uop.prs1", 64'(out_uop.prs1), 64'(e.prs1));
               check_val("out_uop.prs2", 64'(out_uop.prs2), 64'(e.prs2));
               check_val("out_uop.prd", 64'(out_uop.prd), 64'(e.prd));
               check_val("out_uop.pfree", 64'(out_uop.pfree), 64'(e.pfree));
               check_val("out_uop.prd_we", 64'(out_uop.prd_we), 64'(e.prd_we));
            end
         end
         holding = out_valid && !issue_ready;
         held    = out_uop;
      end
   end

   initial begin : main
      int          fd;
      int          n;
      string       line;
      string       rest;
      byte         kind;
      logic [63:0] f [7];
      exp_uop_t    e;
      arst_n      = 1'b0;
      in_valid    = 1'b0;
      instr       = '0;
      pc          = '0;
      cmt         = '0;
      wb          = '0;
      flush       = 1'b0;
      issue_ready = 1'b0;
      lfsr        = 16'd689;
      checks      = 0;
      errors      = 0;
      timeouts    = 0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      fd = $fopen("bench/rename_golden.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open bench/rename_golden.txt");
      end else begin
         while (!$feof(fd) && timeouts == 0) begin
            n = $fgets(line, fd);
            if (n > 1) begin
               kind = line.getc(0);
               rest = line.substr(1, line.len() - 1);
               case (kind)
                  "I": begin
                     n        = $sscanf(rest, "%h %h %d %d %d %d %d",
                                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                     e.pc     = f[1][31:0];
                     e.op     = decoded_op(f[0][31:26]);
                     e.imm    = f[0][15:0];
                     e.lrd    = f[0][25:21];
                     e.reads  = source_reads(e.op);
                     e.prs1   = f[2][31:0];
                     e.prs2   = f[3][31:0];
                     e.prd    = f[4][31:0];
                     e.pfree  = f[5][31:0];
                     e.prd_we = f[6][31:0];
                     send_instr(f[0][31:0], e);
                  end
                  "C": begin
                     n = $sscanf(rest, "%d %d %d %d", f[0], f[1], f[2], f[3]);
                     apply_commit(f[0], f[1], f[2], f[3]);
                  end
                  "W": begin
                     n = $sscanf(rest, "%d", f[0]);
                     pulse_writeback(f[0]);
                  end
                  "B": begin
                     n = $sscanf(rest, "%h", f[0]);
                     check_val("busy", busy, f[0]);
                  end
                  "S": begin
                     n = $sscanf(rest, "%d", f[0]);
                     expect_stall(int'(f[0]));
                  end
                  "F": flush_pipeline();
                  default: ;   // Comment or blank line
               endcase
            end
         end
         $fclose(fd);
      end
      if (timeouts == 0) begin
         drain_outputs();
      end
      $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== rename_unit.f ====
+incdir+logic
logic/rename_pkg.sv
logic/rn_decode.sv
logic/rn_free_list.sv
logic/rn_rat.sv
logic/rn_busytable.sv
logic/rename_unit.sv
bench/rename_unit_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := rename_unit_tb
FILELIST   := rename_unit.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/rename_golden.txt ====
# I instr pc prs1 prs2 prd pfree prd_we | C lrd prd prd_we pfree | W preg | F flush
# B busy | S cycles with in_ready low | instr, pc and busy in hex, registers in decimal
I 04221800 00000100 2 3 32 1 1
I 08410010 00000104 32 0 33 2 1
I 10A20800 00000108 33 32 34 5 0
I 04011000 0000010C 32 33 34 0 0
I 0C620008 00000110 33 0 34 3 1
I 14030800 00000114 34 32 35 0 0
I 1BE00000 00000118 0 0 35 31 1
B 0000000F00000000
W 33
W 32
B 0000000C00000000
C 1 32 1 1
C 2 33 1 2
F
B 0000000000000000
I 0483F800 00000200 3 31 34 4 1
I 08A10004 00000204 32 0 35 5 1
B 0000000C00000000
I 08C60001 00000208 6 0 36 6 1
I 08C60001 0000020C 36 0 37 36 1
I 08C60001 00000210 37 0 38 37 1
I 08C60001 00000214 38 0 39 38 1
I 08C60001 00000218 39 0 40 39 1
I 08C60001 0000021C 40 0 41 40 1
I 08C60001 00000220 41 0 42 41 1
I 08C60001 00000224 42 0 43 42 1
I 08C60001 00000228 43 0 44 43 1
I 08C60001 0000022C 44 0 45 44 1
I 08C60001 00000230 45 0 46 45 1
I 08C60001 00000234 46 0 47 46 1
I 08C60001 00000238 47 0 48 47 1
I 08C60001 0000023C 48 0 49 48 1
I 08C60001 00000240 49 0 50 49 1
I 08C60001 00000244 50 0 51 50 1
I 08C60001 00000248 51 0 52 51 1
I 08C60001 0000024C 52 0 53 52 1
I 08C60001 00000250 53 0 54 53 1
I 08C60001 00000254 54 0 55 54 1
I 08C60001 00000258 55 0 56 55 1
I 08C60001 0000025C 56 0 57 56 1
I 08C60001 00000260 57 0 58 57 1
I 08C60001 00000264 58 0 59 58 1
I 08C60001 00000268 59 0 60 59 1
I 08C60001 0000026C 60 0 61 60 1
I 08C60001 00000270 61 0 62 61 1
I 08C60001 00000274 62 0 63 62 1
I 08C60001 00000278 63 0 1 63 1
I 08C60001 0000027C 1 0 2 1 1
B FFFFFFFC00000006
S 8
C 4 34 1 4
I 04E42800 00000280 34 35 4 7 1
W 34
W 4
B FFFFFFF800000006
F
I 05043000 00000300 34 6 35 8 1
B 0000000800000000
